// File: list.f
logic/mipsPkg.sv
logic/aluDecoder.sv
logic/alu32.sv
logic/registerFile.sv
logic/executeUnit.sv
tb/executeUnit_checker.sv
tb/executeMonitor.sv
tb/executeUnitTb.sv

// File: tb/executeUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnitTb import mipsPkg::*; ();

    localparam int clkPeriod = 4;    // ns
    localparam int numRows   = 24;   // stimulus table depth
    localparam int nameWidth = 8*16; // up to 16 characters

    logic                 clk;
    logic                 rstN;
    logic                 instrValid;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] result;
    logic                 zero;
    logic                 resultValid;
    logic                 illegal;

    // expected values of the applied row for the monitor
    logic [dataWidth-1:0] expResult;
    logic                 expZero;
    logic                 expIllegal;
    logic [nameWidth-1:0] testName;
    logic [31:0]          errorCount;
    logic [31:0]          checkCount;

    // stimulus table
    logic [nameWidth-1:0] rowName    [numRows];
    logic [dataWidth-1:0] rowInstr   [numRows];
    logic [dataWidth-1:0] rowResult  [numRows];
    logic                 rowZero    [numRows];
    logic                 rowIllegal [numRows];
    int                   rowFill;

    executeUnit i_executeUnit (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .result      (result),
        .zero        (zero),
        .resultValid (resultValid),
        .illegal     (illegal)
    );

    executeMonitor i_executeMonitor (
        .clk (clk), .rstN (rstN), .instrValid (instrValid),
        .expResult (expResult), .expZero (expZero), .expIllegal (expIllegal),
        .testName (testName), .result (result), .zero (zero),
        .resultValid (resultValid), .illegal (illegal),
        .errorCount (errorCount), .checkCount (checkCount)
    );

    bind executeUnit executeUnitChecker i_executeUnitChecker (
        .clk (clk), .rstN (rstN), .instrValid (instrValid), .result (result),
        .zero (zero), .resultValid (resultValid), .illegal (illegal)
    );

    //////////////////////////////
    // instruction encoders
    //////////////////////////////
    function automatic logic [31:0] rType(input logic [4:0] rs, rt, rd, shamt, input functE fn);
        return {opSpecial, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] mulType(input logic [4:0] rs, rt, rd);
        return {opSpecial2, rs, rt, rd, 5'd0, fnMul}; // mul rd, rs, rt
    endfunction

    function automatic logic [31:0] iType(input opcodeE op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addRow(input logic [nameWidth-1:0] name, input logic [31:0] ins, res,
                          input logic z, ill);
        rowName[rowFill]    = name;
        rowInstr[rowFill]   = ins;
        rowResult[rowFill]  = res;
        rowZero[rowFill]    = z;
        rowIllegal[rowFill] = ill;
        rowFill++;
    endtask

    //////////////////////////////
    // table with hand-worked expected values
    //////////////////////////////
    task automatic buildTable();
        rowFill = 0;
        addRow("addiNeg", iType(opAddi, 5'd0, 5'd1, 16'hFFFB), 32'hFFFF_FFFB, 1'b0, 1'b0);
        addRow("oriHigh", iType(opOri, 5'd0, 5'd2, 16'h8000), 32'h0000_8000, 1'b0, 1'b0);
        addRow("addiPos", iType(opAddi, 5'd0, 5'd3, 16'h000C), 32'h0000_000C, 1'b0, 1'b0);
        addRow("readNeg", rType(5'd1, 5'd0, 5'd4, 5'd0, fnAdd), 32'hFFFF_FFFB, 1'b0, 1'b0);
        addRow("sub", rType(5'd3, 5'd1, 5'd6, 5'd0, fnSub), 32'h0000_0011, 1'b0, 1'b0);
        addRow("and", rType(5'd1, 5'd3, 5'd7, 5'd0, fnAnd), 32'h0000_0008, 1'b0, 1'b0);
        addRow("or", rType(5'd3, 5'd2, 5'd8, 5'd0, fnOr), 32'h0000_800C, 1'b0, 1'b0);
        addRow("nor", rType(5'd3, 5'd2, 5'd9, 5'd0, fnNor), 32'hFFFF_7FF3, 1'b0, 1'b0);
        addRow("xor", rType(5'd1, 5'd3, 5'd10, 5'd0, fnXor), 32'hFFFF_FFF7, 1'b0, 1'b0);
        addRow("mulNeg", mulType(5'd1, 5'd3, 5'd11), 32'hFFFF_FFC4, 1'b0, 1'b0); // -5 * 12
        addRow("mulWrap", mulType(5'd2, 5'd9, 5'd12), 32'hBFF9_8000, 1'b0, 1'b0); // low word
        addRow("sltNegPos", rType(5'd1, 5'd3, 5'd13, 5'd0, fnSlt), 32'h1, 1'b0, 1'b0);
        addRow("sltPosNeg", rType(5'd3, 5'd1, 5'd14, 5'd0, fnSlt), 32'h0, 1'b1, 1'b0);
        addRow("sltiNeg", iType(opSlti, 5'd1, 5'd15, 16'hFFFF), 32'h1, 1'b0, 1'b0);
        addRow("sll", rType(5'd0, 5'd3, 5'd16, 5'd4, fnSll), 32'h0000_00C0, 1'b0, 1'b0);
        addRow("srlNeg", rType(5'd0, 5'd1, 5'd17, 5'd4, fnSrl), 32'h0FFF_FFFF, 1'b0, 1'b0);
        addRow("subSelf", rType(5'd3, 5'd3, 5'd18, 5'd0, fnSub), 32'h0, 1'b1, 1'b0);
        addRow("andDisjoint", rType(5'd3, 5'd2, 5'd19, 5'd0, fnAnd), 32'h0, 1'b1, 1'b0);
        addRow("writeR0", iType(opAddi, 5'd3, 5'd0, 16'h0007), 32'h0000_0013, 1'b0, 1'b0);
        addRow("readR0", rType(5'd0, 5'd3, 5'd20, 5'd0, fnAdd), 32'h0000_000C, 1'b0, 1'b0);
        // unsupported lw into r3 with the rd field also 3, keeps the readR0 result
        addRow("illegalLw", 32'h8C23_1804, 32'h0000_000C, 1'b0, 1'b1);
        addRow("rtKept", rType(5'd3, 5'd0, 5'd21, 5'd0, fnAdd), 32'h0000_000C, 1'b0, 1'b0);
        addRow("chainWrite", iType(opAddi, 5'd0, 5'd22, 16'h0100), 32'h0000_0100, 1'b0, 1'b0);
        addRow("chainRead", rType(5'd22, 5'd22, 5'd23, 5'd0, fnAdd), 32'h200, 1'b0, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod/2) clk = ~clk;
    end

    // watchdog over table length plus margin
    initial begin
        #((numRows + 20) * clkPeriod);
        $display("timeout: run did not complete within %0d ns", (numRows + 20) * clkPeriod);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        expResult  = '0;
        expZero    = 1'b0;
        expIllegal = 1'b0;
        testName   = '0;
        buildTable();
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;

        for (int i = 0; i < numRows; i++) begin
            @(posedge clk);
            #1;
            instrValid = 1'b1; // one row per cycle back to back
            instr      = rowInstr[i];
            expResult  = rowResult[i];
            expZero    = rowZero[i];
            expIllegal = rowIllegal[i];
            testName   = rowName[i];
        end
        @(posedge clk);
        #1 instrValid = 1'b0;
        repeat (3) @(posedge clk); // let the last pulse drain

        $display("errors: %0d  checks: %0d of %0d", errorCount, checkCount, numRows);
        if (errorCount == 0 && checkCount == numRows) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/executeMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module executeMonitor import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  logic [dataWidth-1:0] expResult,
    input  logic                 expZero,
    input  logic                 expIllegal,
    input  logic [8*16-1:0]      testName,
    input  logic [dataWidth-1:0] result,
    input  logic                 zero,
    input  logic                 resultValid,
    input  logic                 illegal,
    output logic [31:0]          errorCount,
    output logic [31:0]          checkCount
);

    int errors = 0;
    int checks = 0;

    // expectation of the instruction taken on the last edge
    logic                 pendValid;
    logic [dataWidth-1:0] pendResult;
    logic                 pendZero;
    logic                 pendIllegal;
    logic [8*16-1:0]      pendName;

    assign errorCount = errors;
    assign checkCount = checks;

    task automatic reportMismatch(input string what, input logic [31:0] expVal, actVal);
        errors++;
        $display("FAIL %0s %0s: expected %h, actual %h", pendName, what, expVal, actVal);
    endtask

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pendValid <= 1'b0;
        end else begin
            pendValid   <= instrValid;
            pendResult  <= expResult;
            pendZero    <= expZero;
            pendIllegal <= expIllegal;
            pendName    <= testName;
        end
    end

    //////////////////////////////
    // compare mid cycle
    //////////////////////////////
    always @(negedge clk) begin
        if (rstN && pendValid) begin
            checks++;
            if (pendIllegal) begin
                if (!illegal) begin
                    errors++;
                    $display("%0s: illegal pulse missing", pendName);
                end
                if (resultValid) begin
                    errors++;
                    $display("%0s: result pulse raised for an illegal instruction", pendName);
                end
                if (result !== pendResult) reportMismatch("held result", pendResult, result);
            end else if (!resultValid) begin
                errors++;
                $display("%0s: result pulse missing", pendName);
            end else begin
                if (result !== pendResult) reportMismatch("result", pendResult, result);
                if (zero !== pendZero) reportMismatch("zero", pendZero, zero);
                if (illegal) begin
                    errors++;
                    $display("%0s: illegal pulse raised for a legal instruction", pendName);
                end
            end
        end else if (rstN && (resultValid || illegal)) begin
            errors++;
            $display("output pulse seen with no instruction issued");
        end
    end

endmodule

`default_nettype wire

// File: tb/executeUnit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnitChecker import mipsPkg::*; (
    input logic                 clk,
    input logic                 rstN,
    input logic                 instrValid,
    input logic [dataWidth-1:0] result,
    input logic                 zero,
    input logic                 resultValid,
    input logic                 illegal
);

    //////////////////////////////
    // pulse rules
    //////////////////////////////
    notBoth: assert property (@(posedge clk) disable iff (!rstN) !(resultValid && illegal))
        else $error("resultValid and illegal high together");

    // one cycle latency from the strobe
    pulseAfterStrobe: assert property (@(posedge clk) disable iff (!rstN)
        (resultValid || illegal) |-> $past(instrValid))
        else $error("output pulse without a strobe one cycle earlier");

    zeroMatches: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> (zero == (result == '0)))
        else $error("zero flag disagrees with result");

    quietInReset: assert property (@(posedge clk) !rstN |-> (!resultValid && !illegal))
        else $error("pulse high during reset");

endmodule

`default_nettype wire

// File: logic/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit import mipsPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  instrValid, // one-cycle strobe
    input  logic [dataWidth-1:0]  instr,
    output logic [dataWidth-1:0]  result,
    output logic                  zero,
    output logic                  resultValid,
    output logic                  illegal
);

    //////////////////////////////
    // field split
    //////////////////////////////
    opcodeE                  opcode;
    functE                   funct;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [shamtWidth-1:0]   shamt;
    logic [immWidth-1:0]     imm;

    assign opcode = opcodeE'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = functE'(instr[5:0]);
    assign imm    = instr[15:0]; // overlaps rd/shamt/funct

    // decode outputs
    aluOpE aluOp;
    logic  useImm;
    logic  signExtImm;
    logic  destIsRt;
    logic  decIllegal;

    aluDecoder i_aluDecoder (
        .opcode     (opcode),
        .funct      (funct),
        .aluOp      (aluOp),
        .useImm     (useImm),
        .signExtImm (signExtImm),
        .destIsRt   (destIsRt),
        .illegal    (decIllegal)
    );

    //////////////////////////////
    // operands
    //////////////////////////////
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;
    logic [dataWidth-1:0]    immExt;
    logic [dataWidth-1:0]    operandB;
    logic [dataWidth-1:0]    aluResult;
    logic                    aluZero;
    logic                    regWriteEn;
    logic [regAddrWidth-1:0] regWriteAddr;

    assign immExt = signExtImm ? {{(dataWidth-immWidth){imm[immWidth-1]}}, imm}
                               : {{(dataWidth-immWidth){1'b0}}, imm};
    assign operandB = useImm ? immExt : rtData;

    // no write for illegal encodings
    assign regWriteEn   = instrValid && !decIllegal;
    assign regWriteAddr = destIsRt ? rt : rd; // I-type targets rt

    registerFile i_registerFile (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (rs),
        .readAddrB (rt),
        .writeEn   (regWriteEn),
        .writeAddr (regWriteAddr),
        .writeData (aluResult),
        .readDataA (rsData),
        .readDataB (rtData)
    );

    alu32 i_alu32 (
        .aluOp     (aluOp),
        .a         (rsData),
        .b         (operandB),
        .shamt     (shamt),
        .aluResult (aluResult),
        .aluZero   (aluZero)
    );

    //////////////////////////////
    // output registers
    //////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result      <= '0;
            zero        <= 1'b0;
            resultValid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            resultValid <= regWriteEn;                 // pulse, one cycle
            illegal     <= instrValid && decIllegal;
            if (regWriteEn) begin
                result <= aluResult; // held across illegal and idle
                zero   <= aluZero;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import mipsPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [regAddrWidth-1:0]  readAddrA,  // rs
    input  logic [regAddrWidth-1:0]  readAddrB,  // rt
    input  logic                     writeEn,
    input  logic [regAddrWidth-1:0]  writeAddr,
    input  logic [dataWidth-1:0]     writeData,
    output logic [dataWidth-1:0]     readDataA,
    output logic [dataWidth-1:0]     readDataB
);

    logic [dataWidth-1:0] regs [regCount]; // r0 kept but never written

    //////////////////////////////
    // write port
    //////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0; // whole file comes up zero
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData; // r0 writes dropped
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // combinational, so an edge-N write is seen right after edge N
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// File: logic/alu32.sv
`timescale 1ns/1ps
`default_nettype none

module alu32 import mipsPkg::*; (
    input  aluOpE                  aluOp,
    input  logic [dataWidth-1:0]   a,         // rs value
    input  logic [dataWidth-1:0]   b,         // rt value or immediate
    input  logic [shamtWidth-1:0]  shamt,     // shift amount field
    output logic [dataWidth-1:0]   aluResult,
    output logic                   aluZero    // result is all zeros
);

    //////////////////////////////
    // operation select
    //////////////////////////////
    always_comb begin
        case (aluOp)
            aluAdd: aluResult = a + b;
            aluSub: aluResult = a - b;
            aluAnd: aluResult = a & b;
            aluOr:  aluResult = a | b;
            aluNor: aluResult = ~(a | b);
            aluXor: aluResult = a ^ b;
            // shifts take b, amount from shamt
            aluSll: aluResult = b << shamt;
            aluSrl: aluResult = b >> shamt; // logical, zero fill
            // low word of signed product
            aluMul: aluResult = $signed(a) * $signed(b);
            aluSlt: begin
                // signed compare
                if ($signed(a) < $signed(b)) begin
                    aluResult = {{(dataWidth-1){1'b0}}, 1'b1};
                end else begin
                    aluResult = '0;
                end
            end
            default: aluResult = '0; // unused codes 10..15
        endcase
    end

    // flag for a later branch stage
    assign aluZero = (aluResult == '0);

endmodule

`default_nettype wire

// File: logic/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder import mipsPkg::*; (
    input  opcodeE opcode,     // instr[31:26]
    input  functE  funct,      // instr[5:0]
    output aluOpE  aluOp,
    output logic   useImm,     // b operand from immediate
    output logic   signExtImm, // sign vs zero extension
    output logic   destIsRt,   // I-type writes rt
    output logic   illegal     // unsupported encoding
);

    always_comb begin
        // defaults: R-type shape, legal, add
        aluOp      = aluAdd;
        useImm     = 1'b0;
        signExtImm = 1'b0;
        destIsRt   = 1'b0;
        illegal    = 1'b0;

        case (opcode)
            //////////////////////////////
            // R-type
            //////////////////////////////
            opSpecial: begin
                case (funct)
                    fnSll:   aluOp = aluSll; // shifts act on rt
                    fnSrl:   aluOp = aluSrl;
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnNor:   aluOp = aluNor;
                    fnSlt:   aluOp = aluSlt;
                    default: illegal = 1'b1; // unknown funct
                endcase
            end

            // mul rd, rs, rt
            opSpecial2: begin
                if (funct == fnMul) begin
                    aluOp = aluMul;
                end else begin
                    illegal = 1'b1;
                end
            end

            //////////////////////////////
            // I-type alu
            //////////////////////////////
            opAddi: begin
                aluOp      = aluAdd;
                useImm     = 1'b1;
                signExtImm = 1'b1; // signed immediate
                destIsRt   = 1'b1;
            end
            opSlti: begin
                aluOp      = aluSlt;
                useImm     = 1'b1;
                signExtImm = 1'b1;
                destIsRt   = 1'b1;
            end
            opAndi: begin
                aluOp    = aluAnd;
                useImm   = 1'b1; // logical ops zero-extend
                destIsRt = 1'b1;
            end
            opOri: begin
                aluOp    = aluOr;
                useImm   = 1'b1;
                destIsRt = 1'b1;
            end
            opXori: begin
                aluOp    = aluXor;
                useImm   = 1'b1;
                destIsRt = 1'b1;
            end

            default: begin
                illegal = 1'b1; // loads, branches etc. not handled here
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mipsPkg.sv
`default_nettype none

package mipsPkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int dataWidth    = 32; // datapath word
    localparam int regAddrWidth = 5;  // register index
    localparam int regCount     = 32; // register file depth
    localparam int shamtWidth   = 5;  // shift amount field
    localparam int immWidth     = 16; // I-type immediate
    localparam int fieldWidth   = 6;  // opcode and funct fields

    // SPECIAL2 mul shares its funct value with srl
    localparam logic [fieldWidth-1:0] fnMul = 6'h02;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // primary opcode in instr[31:26]
    typedef enum logic [fieldWidth-1:0] {
        opSpecial  = 6'h00, // R-type
        opAddi     = 6'h08,
        opSlti     = 6'h0A,
        opAndi     = 6'h0C,
        opOri      = 6'h0D,
        opXori     = 6'h0E,
        opSpecial2 = 6'h1C  // mul lives here
    } opcodeE;

    // R-type funct in instr[5:0]
    typedef enum logic [fieldWidth-1:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnNor = 6'h27,
        fnSlt = 6'h2A
    } functE;

    // alu control codes 0 to 9
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluNor = 4'd4,
        aluXor = 4'd5,
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluMul = 4'd8,
        aluSlt = 4'd9
    } aluOpE;

endpackage

`default_nettype wire
